// ==== hdl/rename_pkg.sv ====
package rename_pkg;

   // Architectural register file
   localparam int ARF_NUM   = 32;
   localparam int ARF_WIDTH = $clog2(ARF_NUM);   // 5 bits, x0..x31

   // Physical register file
   localparam int PRF_NUM   = 64;
   localparam int PRF_WIDTH = $clog2(PRF_NUM);   // 6 bits

   // Free list holds every PRF id not mapped at reset
   localparam int FL_DEPTH     = PRF_NUM - ARF_NUM;       // 32 slots
   localparam int FL_PTR_WIDTH = $clog2(FL_DEPTH) + 1;    // Slot index plus wrap bit

   // ROB state, drives allocation and recovery
   localparam logic [1:0] ROB_NORMAL  = 2'b00;   // Rename as usual
   localparam logic [1:0] ROB_RECOVER = 2'b01;   // Restore RAT and FL head this cycle
   localparam logic [1:0] ROB_STALL   = 2'b10;   // ROB full, hold allocation

   // Decoded instruction as seen by rename
   // Field order sets the packed layout, is_valid is the MSB
   typedef struct packed {
      logic                 is_valid;    // Slot carries an instruction
      logic                 reg_write;   // Writes rd
      logic [ARF_WIDTH-1:0] rd_id;       // Destination
      logic [ARF_WIDTH-1:0] rs1_id;      // Source 1
      logic [ARF_WIDTH-1:0] rs2_id;      // Source 2
   } control_type;

endpackage

// ==== hdl/freelist.sv ====
`timescale 1ns/1ps

module freelist (
   input  logic                           clk,
   input  logic                           arst_n,
   // Allocation requests from rename
   input  logic                           req_0,
   input  logic                           req_1,
   // Released PRF ids, slot 0 goes in first
   input  logic                           write_en_0,
   input  logic                           write_en_1,
   input  logic [rename_pkg::PRF_WIDTH-1:0] write_data_0,
   input  logic [rename_pkg::PRF_WIDTH-1:0] write_data_1,
   // One pulse per retired writer
   input  logic                           commit_0,
   input  logic                           commit_1,
   input  logic [1:0]                     rob_state,
   output logic [rename_pkg::PRF_WIDTH-1:0] resp_prf_0,
   output logic [rename_pkg::PRF_WIDTH-1:0] resp_prf_1,
   output logic                           can_alloc
);
   import rename_pkg::*;

   logic [PRF_WIDTH-1:0]    fl_mem [FL_DEPTH];   // Ring of free PRF ids

   logic [FL_PTR_WIDTH-1:0] head_spec;           // Next id handed out
   logic [FL_PTR_WIDTH-1:0] head_commit;         // Head as seen by retirement
   logic [FL_PTR_WIDTH-1:0] tail;                // Next free slot to fill
   logic [FL_PTR_WIDTH-1:0] head_spec_p1;
   logic [FL_PTR_WIDTH-1:0] tail_p1;
   logic [FL_PTR_WIDTH-1:0] head_commit_nxt;
   logic [FL_PTR_WIDTH-1:0] alloc_cnt;
   logic [FL_PTR_WIDTH-1:0] commit_cnt;
   logic [FL_PTR_WIDTH-1:0] push_cnt;
   logic [FL_PTR_WIDTH-1:0] free_cnt;
   logic                    alloc_0;
   logic                    alloc_1;

   // Allocation only happens in normal state
   assign alloc_0 = req_0 && (rob_state == ROB_NORMAL);
   assign alloc_1 = req_1 && (rob_state == ROB_NORMAL);

   assign head_spec_p1 = head_spec + FL_PTR_WIDTH'(1);
   assign tail_p1      = tail + FL_PTR_WIDTH'(1);

   assign alloc_cnt  = FL_PTR_WIDTH'(alloc_0) + FL_PTR_WIDTH'(alloc_1);
   assign commit_cnt = FL_PTR_WIDTH'(commit_0) + FL_PTR_WIDTH'(commit_1);
   assign push_cnt   = FL_PTR_WIDTH'(write_en_0) + FL_PTR_WIDTH'(write_en_1);

   // Committed head after this edge, recovery restores to it
   assign head_commit_nxt = head_commit + commit_cnt;

   // Wrap bit makes full (32) and empty (0) distinct
   assign free_cnt  = tail - head_spec;
   assign can_alloc = (free_cnt > FL_PTR_WIDTH'(1));   // Room for a full pair

   // Head entry to the first requester
   assign resp_prf_0 = fl_mem[head_spec[FL_PTR_WIDTH-2:0]];
   // Slot 1 takes the head when slot 0 is idle
   assign resp_prf_1 = req_0 ? fl_mem[head_spec_p1[FL_PTR_WIDTH-2:0]]
                             : fl_mem[head_spec[FL_PTR_WIDTH-2:0]];

   // Slot storage, reset loads ARF_NUM..PRF_NUM-1 in order
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         for (int i = 0; i < FL_DEPTH; i++) begin
            fl_mem[i] <= PRF_WIDTH'(ARF_NUM + i);
         end
      end else begin
         if (write_en_0) begin
            fl_mem[tail[FL_PTR_WIDTH-2:0]] <= write_data_0;
         end
         if (write_en_1) begin
            // Lands behind slot 0 when both push
            if (write_en_0) begin
               fl_mem[tail_p1[FL_PTR_WIDTH-2:0]] <= write_data_1;
            end else begin
               fl_mem[tail[FL_PTR_WIDTH-2:0]] <= write_data_1;
            end
         end
      end
   end

   // Pointers
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         head_spec   <= '0;
         head_commit <= '0;
         tail        <= FL_PTR_WIDTH'(FL_DEPTH);   // Wrapped once, ring full
      end else begin
         tail        <= tail + push_cnt;           // Frees in every state
         head_commit <= head_commit_nxt;
         case (rob_state)
            ROB_RECOVER: head_spec <= head_commit_nxt;   // Drop speculative allocs
            ROB_NORMAL:  head_spec <= head_spec + alloc_cnt;
            ROB_STALL:   head_spec <= head_spec;         // ROB full
            default:     head_spec <= head_spec;
         endcase
      end
   end

endmodule

// ==== hdl/maptable.sv ====
`timescale 1ns/1ps

module maptable (
   input  logic                             clk,
   input  logic                             arst_n,
   // New destinations from rename
   input  logic                             rd_valid_0,
   input  logic                             rd_valid_1,
   input  logic [rename_pkg::ARF_WIDTH-1:0] rd_id_0,
   input  logic [rename_pkg::ARF_WIDTH-1:0] rd_id_1,
   input  logic [rename_pkg::ARF_WIDTH-1:0] rs1_id_0,
   input  logic [rename_pkg::ARF_WIDTH-1:0] rs2_id_0,
   input  logic [rename_pkg::ARF_WIDTH-1:0] rs1_id_1,
   input  logic [rename_pkg::ARF_WIDTH-1:0] rs2_id_1,
   input  logic [rename_pkg::PRF_WIDTH-1:0] fl_prf_id_0,
   input  logic [rename_pkg::PRF_WIDTH-1:0] fl_prf_id_1,
   // Retirement
   input  logic                             retire_valid_0,
   input  logic                             retire_valid_1,
   input  logic                             retire_wb_0,
   input  logic                             retire_wb_1,
   input  logic [rename_pkg::ARF_WIDTH-1:0] retire_arf_id_0,
   input  logic [rename_pkg::ARF_WIDTH-1:0] retire_arf_id_1,
   input  logic [rename_pkg::PRF_WIDTH-1:0] retire_prf_id_0,
   input  logic [rename_pkg::PRF_WIDTH-1:0] retire_prf_id_1,
   input  logic [1:0]                       rob_state,
   // Renamed sources
   output logic [rename_pkg::PRF_WIDTH-1:0] instr0_prf_rs1,
   output logic [rename_pkg::PRF_WIDTH-1:0] instr0_prf_rs2,
   output logic [rename_pkg::PRF_WIDTH-1:0] instr1_prf_rs1,
   output logic [rename_pkg::PRF_WIDTH-1:0] instr1_prf_rs2,
   // New and previous destinations
   output logic [rename_pkg::PRF_WIDTH-1:0] T_0,
   output logic [rename_pkg::PRF_WIDTH-1:0] T_1,
   output logic [rename_pkg::PRF_WIDTH-1:0] T_old_0,
   output logic [rename_pkg::PRF_WIDTH-1:0] T_old_1,
   output logic [rename_pkg::PRF_WIDTH-1:0] rrat_debug [rename_pkg::ARF_NUM]
);
   import rename_pkg::*;

   logic [PRF_WIDTH-1:0] rat      [ARF_NUM];   // Speculative map
   logic [PRF_WIDTH-1:0] rrat     [ARF_NUM];   // Committed map
   logic [PRF_WIDTH-1:0] rrat_nxt [ARF_NUM];   // RRAT after this edge's retires

   logic hit_rs1_1;   // Instr 1 rs1 produced by instr 0
   logic hit_rs2_1;
   logic hit_rd_1;    // Both write the same rd
   logic recover;
   logic ret_wr_0;
   logic ret_wr_1;

   assign recover  = (rob_state == ROB_RECOVER);
   assign ret_wr_0 = retire_valid_0 && retire_wb_0;
   assign ret_wr_1 = retire_valid_1 && retire_wb_1;

   // Intra-group dependence, rd_valid_0 already excludes x0
   assign hit_rs1_1 = rd_valid_0 && (rs1_id_1 == rd_id_0);
   assign hit_rs2_1 = rd_valid_0 && (rs2_id_1 == rd_id_0);
   assign hit_rd_1  = rd_valid_0 && (rd_id_1 == rd_id_0);

   // Instr 0 reads the RAT as is
   assign instr0_prf_rs1 = rat[rs1_id_0];
   assign instr0_prf_rs2 = rat[rs2_id_0];

   // Instr 1 sees instr 0's new mapping first
   assign instr1_prf_rs1 = hit_rs1_1 ? fl_prf_id_0 : rat[rs1_id_1];
   assign instr1_prf_rs2 = hit_rs2_1 ? fl_prf_id_0 : rat[rs2_id_1];

   assign T_0 = rd_valid_0 ? fl_prf_id_0 : '0;   // Zero without allocation
   assign T_1 = rd_valid_1 ? fl_prf_id_1 : '0;

   assign T_old_0 = rat[rd_id_0];
   assign T_old_1 = hit_rd_1 ? fl_prf_id_0 : rat[rd_id_1];   // Frees instr 0's id later

   // Retire writes, slot 1 last so it wins on the same rd
   always_comb begin
      rrat_nxt = rrat;
      if (ret_wr_0) begin
         rrat_nxt[retire_arf_id_0] = retire_prf_id_0;
      end
      if (ret_wr_1) begin
         rrat_nxt[retire_arf_id_1] = retire_prf_id_1;
      end
   end

   // RRAT, identity at reset
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         for (int i = 0; i < ARF_NUM; i++) begin
            rrat[i] <= PRF_WIDTH'(i);
         end
      end else begin
         rrat <= rrat_nxt;
      end
   end

   // RAT
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         for (int i = 0; i < ARF_NUM; i++) begin
            rat[i] <= PRF_WIDTH'(i);
         end
      end else if (recover) begin
         rat <= rrat_nxt;   // Includes retires at this edge
      end else begin
         if (rd_valid_0) begin
            rat[rd_id_0] <= fl_prf_id_0;
         end
         if (rd_valid_1) begin
            rat[rd_id_1] <= fl_prf_id_1;   // Younger wins on same rd
         end
      end
   end

   assign rrat_debug = rrat;

endmodule

// ==== hdl/ir_stage.sv ====
`timescale 1ns/1ps

module ir_stage (
   input  logic                             clk,
   input  logic                             arst_n,
   // Decode
   input  rename_pkg::control_type          dec_instr0,
   input  rename_pkg::control_type          dec_instr1,
   input  logic                             ID_stall,
   // Released PRF ids from the ROB
   input  logic                             fl_write_en_0,
   input  logic                             fl_write_en_1,
   input  logic [rename_pkg::PRF_WIDTH-1:0] fl_write_data_0,
   input  logic [rename_pkg::PRF_WIDTH-1:0] fl_write_data_1,
   // Retire
   input  logic                             retire_valid_0,
   input  logic                             retire_valid_1,
   input  logic                             retire_wb_0,
   input  logic                             retire_wb_1,
   input  logic [rename_pkg::ARF_WIDTH-1:0] retire_arf_id_0,
   input  logic [rename_pkg::ARF_WIDTH-1:0] retire_arf_id_1,
   input  logic [rename_pkg::PRF_WIDTH-1:0] retire_prf_id_0,
   input  logic [rename_pkg::PRF_WIDTH-1:0] retire_prf_id_1,
   input  logic [1:0]                       rob_state,
   // To RS and ROB
   output logic                             fl_can_alloc,
   output logic [rename_pkg::PRF_WIDTH-1:0] T_0,
   output logic [rename_pkg::PRF_WIDTH-1:0] T_1,
   output logic [rename_pkg::PRF_WIDTH-1:0] T_old_0,
   output logic [rename_pkg::PRF_WIDTH-1:0] T_old_1,
   output logic [rename_pkg::PRF_WIDTH-1:0] instr0_prf_rs1,
   output logic [rename_pkg::PRF_WIDTH-1:0] instr0_prf_rs2,
   output logic [rename_pkg::PRF_WIDTH-1:0] instr1_prf_rs1,
   output logic [rename_pkg::PRF_WIDTH-1:0] instr1_prf_rs2,
   output logic [rename_pkg::PRF_WIDTH-1:0] rrat_debug [rename_pkg::ARF_NUM]
);
   import rename_pkg::*;

   logic                 fl_req_0;
   logic                 fl_req_1;
   logic [PRF_WIDTH-1:0] resp_prf_0;
   logic [PRF_WIDTH-1:0] resp_prf_1;
   logic                 commit_0;
   logic                 commit_1;
   logic                 alloc_ok;

   // Stage may allocate this cycle
   assign alloc_ok = !ID_stall && (rob_state == ROB_NORMAL);

   // Valid writer of a real register, x0 never renamed
   assign fl_req_0 = alloc_ok && dec_instr0.is_valid && dec_instr0.reg_write
                     && (dec_instr0.rd_id != '0);
   assign fl_req_1 = alloc_ok && dec_instr1.is_valid && dec_instr1.reg_write
                     && (dec_instr1.rd_id != '0);

   // Each retired writer moves the committed head
   assign commit_0 = retire_valid_0 && retire_wb_0;
   assign commit_1 = retire_valid_1 && retire_wb_1;

   freelist inst_fl (
      .clk          (clk),
      .arst_n       (arst_n),
      .req_0        (fl_req_0),
      .req_1        (fl_req_1),
      .write_en_0   (fl_write_en_0),
      .write_en_1   (fl_write_en_1),
      .write_data_0 (fl_write_data_0),
      .write_data_1 (fl_write_data_1),
      .commit_0     (commit_0),
      .commit_1     (commit_1),
      .rob_state    (rob_state),
      .resp_prf_0   (resp_prf_0),
      .resp_prf_1   (resp_prf_1),
      .can_alloc    (fl_can_alloc)
   );

   maptable inst_mt (
      .clk             (clk),
      .arst_n          (arst_n),
      .rd_valid_0      (fl_req_0),   // RAT write follows the allocation
      .rd_valid_1      (fl_req_1),
      .rd_id_0         (dec_instr0.rd_id),
      .rd_id_1         (dec_instr1.rd_id),
      .rs1_id_0        (dec_instr0.rs1_id),
      .rs2_id_0        (dec_instr0.rs2_id),
      .rs1_id_1        (dec_instr1.rs1_id),
      .rs2_id_1        (dec_instr1.rs2_id),
      .fl_prf_id_0     (resp_prf_0),
      .fl_prf_id_1     (resp_prf_1),
      .retire_valid_0  (retire_valid_0),
      .retire_valid_1  (retire_valid_1),
      .retire_wb_0     (retire_wb_0),
      .retire_wb_1     (retire_wb_1),
      .retire_arf_id_0 (retire_arf_id_0),
      .retire_arf_id_1 (retire_arf_id_1),
      .retire_prf_id_0 (retire_prf_id_0),
      .retire_prf_id_1 (retire_prf_id_1),
      .rob_state       (rob_state),
      .instr0_prf_rs1  (instr0_prf_rs1),
      .instr0_prf_rs2  (instr0_prf_rs2),
      .instr1_prf_rs1  (instr1_prf_rs1),
      .instr1_prf_rs2  (instr1_prf_rs2),
      .T_0             (T_0),
      .T_1             (T_1),
      .T_old_0         (T_old_0),
      .T_old_1         (T_old_1),
      .rrat_debug      (rrat_debug)
   );

endmodule

// ==== tb/ir_stage_assert.sv ====
`timescale 1ns/1ps

module ir_stage_assert (
   input logic                                clk,
   input logic                                arst_n,
   input logic                                fl_req_0,
   input logic                                fl_req_1,
   input logic                                fl_can_alloc,
   input logic [rename_pkg::PRF_WIDTH-1:0]    resp_prf_0,
   input logic [rename_pkg::PRF_WIDTH-1:0]    resp_prf_1,
   input logic [1:0]                          rob_state,
   input logic [rename_pkg::FL_PTR_WIDTH-1:0] head_spec,
   input logic [rename_pkg::FL_PTR_WIDTH-1:0] head_commit
);
   import rename_pkg::*;

   int err_cnt = 0;   // Failed assertions so far

   // Decode must stall when fewer than two ids are free
   req_needs_room: assert property (@(posedge clk) disable iff (!arst_n)
      (fl_req_0 || fl_req_1) |-> fl_can_alloc)
      else begin
         $error("allocation request while free list short");
         err_cnt++;
      end

   // Pair gets two distinct ids
   pair_distinct: assert property (@(posedge clk) disable iff (!arst_n)
      (fl_req_0 && fl_req_1) |-> (resp_prf_0 != resp_prf_1))
      else begin
         $error("dual allocation returned the same id");
         err_cnt++;
      end

   // Head lands exactly on the committed head, no id taken in that cycle
   no_alloc_in_recover: assert property (@(posedge clk) disable iff (!arst_n)
      (rob_state == ROB_RECOVER) |=> (head_spec == head_commit))
      else begin
         $error("allocation during recovery");
         err_cnt++;
      end

endmodule

bind ir_stage ir_stage_assert u_assert (
   .clk          (clk),
   .arst_n       (arst_n),
   .fl_req_0     (fl_req_0),
   .fl_req_1     (fl_req_1),
   .fl_can_alloc (fl_can_alloc),
   .resp_prf_0   (resp_prf_0),
   .resp_prf_1   (resp_prf_1),
   .rob_state    (rob_state),
   .head_spec    (inst_fl.head_spec),
   .head_commit  (inst_fl.head_commit)
);

// ==== tb/ir_stage_tb.sv ====
`timescale 1ns/1ps

module ir_stage_tb;
   import rename_pkg::*;

   localparam int CLK_PERIOD  = 40;
   localparam int RESET_CYC   = 16;
   localparam int DRIVE_DELAY = 2;    // Inputs settle after the edge

   // One row of stimulus and its expected responses
   typedef struct {
      string                name;
      control_type          i0;
      control_type          i1;
      logic                 stall;
      logic [1:0]           rob;
      int                   rep;       // Cycles this row is held
      logic                 ret0;      // Retire with writeback, slot 0
      logic [ARF_WIDTH-1:0] ret_arf0;
      logic [PRF_WIDTH-1:0] ret_prf0;
      logic                 ret1;
      logic [ARF_WIDTH-1:0] ret_arf1;
      logic [PRF_WIDTH-1:0] ret_prf1;
      logic                 fr0;       // Free pushes
      logic [PRF_WIDTH-1:0] fr_id0;
      logic                 fr1;
      logic [PRF_WIDTH-1:0] fr_id1;
      logic [PRF_WIDTH-1:0] e_t0;
      logic [PRF_WIDTH-1:0] e_t1;
      logic [PRF_WIDTH-1:0] e_told0;
      logic [PRF_WIDTH-1:0] e_told1;
      logic [PRF_WIDTH-1:0] e_s01;
      logic [PRF_WIDTH-1:0] e_s02;
      logic [PRF_WIDTH-1:0] e_s11;
      logic [PRF_WIDTH-1:0] e_s12;
      logic                 e_can;
   } row_t;

   logic                 clk;
   logic                 arst_n;
   control_type          dec_instr0;
   control_type          dec_instr1;
   logic                 ID_stall;
   logic                 fl_write_en_0;
   logic                 fl_write_en_1;
   logic [PRF_WIDTH-1:0] fl_write_data_0;
   logic [PRF_WIDTH-1:0] fl_write_data_1;
   logic                 retire_valid_0;
   logic                 retire_valid_1;
   logic                 retire_wb_0;
   logic                 retire_wb_1;
   logic [ARF_WIDTH-1:0] retire_arf_id_0;
   logic [ARF_WIDTH-1:0] retire_arf_id_1;
   logic [PRF_WIDTH-1:0] retire_prf_id_0;
   logic [PRF_WIDTH-1:0] retire_prf_id_1;
   logic [1:0]           rob_state;
   logic                 fl_can_alloc;
   logic [PRF_WIDTH-1:0] T_0;
   logic [PRF_WIDTH-1:0] T_1;
   logic [PRF_WIDTH-1:0] T_old_0;
   logic [PRF_WIDTH-1:0] T_old_1;
   logic [PRF_WIDTH-1:0] instr0_prf_rs1;
   logic [PRF_WIDTH-1:0] instr0_prf_rs2;
   logic [PRF_WIDTH-1:0] instr1_prf_rs1;
   logic [PRF_WIDTH-1:0] instr1_prf_rs2;
   logic [PRF_WIDTH-1:0] rrat_debug [ARF_NUM];

   row_t rows[$];
   int   cycles      = 0;
   int   cycle_limit = 0;   // Zero until the table is built
   int   pass_cnt    = 0;
   int   fail_cnt    = 0;
   int   row_errs;

   ir_stage dut0 (.*);

   initial begin
      clk = 1'b0;
      forever #(CLK_PERIOD/2) clk = ~clk;
   end

   // Watchdog
   initial begin
      forever begin
         @(posedge clk);
         cycles++;
         if (cycle_limit > 0 && cycles > cycle_limit) begin
            $display("Run did not finish within %0d cycles", cycle_limit);
            $display("TB FAILED");
            $finish;
         end
      end
   end

   function automatic control_type instr(int v, int w, int rd, int rs1, int rs2);
      control_type c;
      c.is_valid  = 1'(v);
      c.reg_write = 1'(w);
      c.rd_id     = ARF_WIDTH'(rd);
      c.rs1_id    = ARF_WIDTH'(rs1);
      c.rs2_id    = ARF_WIDTH'(rs2);
      return c;
   endfunction

   // Expected order: T0 T1 Told0 Told1, then sources, then can_alloc
   task automatic add_row(string name, control_type i0, control_type i1, int stall,
                          int rob, int rep, int t0, int t1, int to0, int to1,
                          int s01, int s02, int s11, int s12, int can);
      row_t r;
      r          = '{name: "", default: '0};
      r.name     = name;
      r.i0       = i0;
      r.i1       = i1;
      r.stall    = 1'(stall);
      r.rob      = 2'(rob);
      r.rep      = rep;
      r.e_t0     = PRF_WIDTH'(t0);
      r.e_t1     = PRF_WIDTH'(t1);
      r.e_told0  = PRF_WIDTH'(to0);
      r.e_told1  = PRF_WIDTH'(to1);
      r.e_s01    = PRF_WIDTH'(s01);
      r.e_s02    = PRF_WIDTH'(s02);
      r.e_s11    = PRF_WIDTH'(s11);
      r.e_s12    = PRF_WIDTH'(s12);
      r.e_can    = 1'(can);
      rows.push_back(r);
   endtask

   // Retire on the last row added, arf id 0 leaves a slot idle
   task automatic add_retire(int arf0, int prf0, int arf1, int prf1);
      rows[$].ret0     = (arf0 != 0);
      rows[$].ret_arf0 = ARF_WIDTH'(arf0);
      rows[$].ret_prf0 = PRF_WIDTH'(prf0);
      rows[$].ret1     = (arf1 != 0);
      rows[$].ret_arf1 = ARF_WIDTH'(arf1);
      rows[$].ret_prf1 = PRF_WIDTH'(prf1);
   endtask

   task automatic add_free(int id0, int id1);
      rows[$].fr0    = 1'b1;
      rows[$].fr_id0 = PRF_WIDTH'(id0);
      rows[$].fr1    = 1'b1;
      rows[$].fr_id1 = PRF_WIDTH'(id1);
   endtask

   task automatic drive_row(row_t r);
      dec_instr0      = r.i0;
      dec_instr1      = r.i1;
      ID_stall        = r.stall;
      rob_state       = r.rob;
      retire_valid_0  = r.ret0;
      retire_wb_0     = r.ret0;
      retire_arf_id_0 = r.ret_arf0;
      retire_prf_id_0 = r.ret_prf0;
      retire_valid_1  = r.ret1;
      retire_wb_1     = r.ret1;
      retire_arf_id_1 = r.ret_arf1;
      retire_prf_id_1 = r.ret_prf1;
      fl_write_en_0   = r.fr0;
      fl_write_data_0 = r.fr_id0;
      fl_write_en_1   = r.fr1;
      fl_write_data_1 = r.fr_id1;
   endtask

   task automatic check_value(string test, string field, logic [PRF_WIDTH-1:0] exp,
                              logic [PRF_WIDTH-1:0] act);
      if (act !== exp) begin
         $display("ERROR %s %s expected %0d actual %0d", test, field, exp, act);
         row_errs++;
      end
   endtask

   // Committed map after the retire rows, other registers stay identity
   task automatic check_rrat();
      logic [PRF_WIDTH-1:0] exp;
      row_errs = 0;
      for (int a = 0; a < ARF_NUM; a++) begin
         case (a)
            1:       exp = PRF_WIDTH'(32);   // Retired in row retire
            2:       exp = PRF_WIDTH'(33);
            3:       exp = PRF_WIDTH'(34);   // Retired with the recovery
            default: exp = PRF_WIDTH'(a);
         endcase
         check_value("rrat_final", $sformatf("rrat_debug[%0d]", a), exp, rrat_debug[a]);
      end
      if (row_errs == 0) begin
         $display("PASS rrat_final");
         pass_cnt++;
      end else begin
         fail_cnt++;
      end
   endtask

   initial begin
      int   total_rep;
      row_t idle;
      idle   = '{name: "idle", default: '0};
      arst_n = 1'b0;
      drive_row(idle);

      // Hand-derived table, RAT identity and FL 32..63 at start
      add_row("reset_read", instr(0,0,0,5,6), instr(0,0,0,7,8), 0, ROB_NORMAL, 1,
              0, 0, 0, 0, 5, 6, 7, 8, 1);
      add_row("alloc_pair", instr(1,1,1,2,3), instr(1,1,2,3,4), 0, ROB_NORMAL, 1,
              32, 33, 1, 2, 2, 3, 3, 4, 1);
      add_row("read_new", instr(1,1,3,1,2), instr(1,1,4,1,5), 0, ROB_NORMAL, 1,
              34, 35, 3, 4, 32, 33, 32, 5, 1);
      add_row("bypass", instr(1,1,5,1,0), instr(1,1,5,5,3), 0, ROB_NORMAL, 1,
              36, 37, 5, 36, 32, 0, 36, 34, 1);
      add_row("x0_no_alloc", instr(1,1,0,5,4), instr(1,0,6,5,0), 0, ROB_NORMAL, 1,
              0, 0, 0, 6, 37, 35, 37, 0, 1);
      add_row("stall_hold", instr(1,1,6,1,2), instr(0,1,7,3,4), 1, ROB_NORMAL, 1,
              0, 0, 6, 7, 32, 33, 34, 35, 1);
      add_row("slot1_only", instr(0,1,0,0,0), instr(1,1,6,6,7), 0, ROB_NORMAL, 1,
              0, 38, 0, 6, 0, 0, 6, 7, 1);
      add_row("slot0_only", instr(1,1,7,6,5), instr(0,0,0,7,0), 0, ROB_NORMAL, 1,
              39, 0, 7, 0, 38, 37, 39, 0, 1);
      // Recovery: commit x1 x2, rename past them, then restore
      add_row("retire", instr(0,0,0,1,2), instr(0,0,0,3,4), 1, ROB_NORMAL, 1,
              0, 0, 0, 0, 32, 33, 34, 35, 1);
      add_retire(1, 32, 2, 33);
      add_row("spec_rename", instr(1,1,1,1,2), instr(1,1,3,1,3), 0, ROB_NORMAL, 1,
              40, 41, 32, 34, 32, 33, 40, 34, 1);
      add_row("recover", instr(1,1,5,1,3), instr(0,0,0,2,0), 0, ROB_RECOVER, 1,
              0, 0, 37, 0, 40, 41, 33, 0, 1);
      add_retire(3, 34, 0, 0);
      add_row("after_recover", instr(1,1,4,1,3), instr(1,1,5,2,5), 0, ROB_NORMAL, 1,
              35, 36, 4, 5, 32, 34, 33, 5, 1);
      add_row("slot0_single", instr(1,1,6,4,5), instr(0,0,0,0,6), 0, ROB_NORMAL, 1,
              37, 0, 6, 0, 35, 36, 0, 37, 1);
      // Drain the free list down to two entries
      add_row("fill", instr(1,1,8,8,9), instr(1,1,9,8,9), 0, ROB_NORMAL, 12,
              60, 61, 58, 59, 58, 59, 60, 59, 1);
      add_row("last_pair", instr(1,1,10,8,9), instr(1,1,11,10,11), 0, ROB_NORMAL, 1,
              62, 63, 10, 11, 60, 61, 62, 11, 1);
      add_row("empty_free", instr(0,0,0,10,11), instr(0,0,0,1,2), 1, ROB_NORMAL, 1,
              0, 0, 0, 0, 62, 63, 32, 33, 0);
      add_free(4, 5);
      add_row("recycle", instr(1,1,12,12,0), instr(1,1,13,12,13), 0, ROB_NORMAL, 1,
              4, 5, 12, 13, 12, 0, 4, 13, 1);
      add_row("drained", instr(0,0,0,12,13), instr(0,0,0,8,9), 1, ROB_NORMAL, 1,
              0, 0, 0, 0, 4, 5, 60, 61, 0);

      total_rep = 0;
      foreach (rows[i]) total_rep += rows[i].rep;
      cycle_limit = RESET_CYC + total_rep + 100;

      repeat (RESET_CYC) @(posedge clk);
      #DRIVE_DELAY arst_n = 1'b1;

      foreach (rows[i]) begin
         for (int k = 0; k < rows[i].rep; k++) begin
            @(posedge clk);
            #DRIVE_DELAY drive_row(rows[i]);
            #(CLK_PERIOD - DRIVE_DELAY - 1);   // Just before the next edge
            if (k == rows[i].rep - 1) begin
               row_errs = 0;
               check_value(rows[i].name, "T_0", rows[i].e_t0, T_0);
               check_value(rows[i].name, "T_1", rows[i].e_t1, T_1);
               check_value(rows[i].name, "T_old_0", rows[i].e_told0, T_old_0);
               check_value(rows[i].name, "T_old_1", rows[i].e_told1, T_old_1);
               check_value(rows[i].name, "instr0_prf_rs1", rows[i].e_s01, instr0_prf_rs1);
               check_value(rows[i].name, "instr0_prf_rs2", rows[i].e_s02, instr0_prf_rs2);
               check_value(rows[i].name, "instr1_prf_rs1", rows[i].e_s11, instr1_prf_rs1);
               check_value(rows[i].name, "instr1_prf_rs2", rows[i].e_s12, instr1_prf_rs2);
               check_value(rows[i].name, "fl_can_alloc", PRF_WIDTH'(rows[i].e_can),
                           PRF_WIDTH'(fl_can_alloc));
               if (row_errs == 0) begin
                  $display("PASS %s", rows[i].name);
                  pass_cnt++;
               end else begin
                  fail_cnt++;
               end
            end
         end
      end

      check_rrat();

      @(posedge clk);
      #DRIVE_DELAY drive_row(idle);
      $display("Rows passed %0d, rows failed %0d, assertion failures %0d",
               pass_cnt, fail_cnt, dut0.u_assert.err_cnt);
      if (fail_cnt == 0 && dut0.u_assert.err_cnt == 0) begin
         $display("TB PASSED");
      end else begin
         $display("TB FAILED");
      end
      $finish;
   end

endmodule

// ==== all.f ====
hdl/rename_pkg.sv
hdl/freelist.sv
hdl/maptable.sv
hdl/ir_stage.sv
tb/ir_stage_assert.sv
tb/ir_stage_tb.sv

// ==== Makefile ====
# Verilator build and run of the rename stage testbench

VERILATOR ?= verilator
TOP       ?= ir_stage_tb
LOG       ?= sim.log
BUILD     ?= obj_dir
FILELIST  ?= all.f
VFLAGS    ?= --binary --timing --assert

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, check $(LOG) for the pass message"
	@echo "  clean  remove $(BUILD) and $(LOG)"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP LOG BUILD FILELIST VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD)
	./$(BUILD)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "TB PASSED" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
